/* Bender.yml */
package:
  name: inserter

sources:
  - include_dirs:
      - .
    files:
      - inserter_pkg.sv
      - frame_edges_if.sv
      - coarse_flag_blocker.sv
      - start_frame_decoder.sv
      - fifo_controller.sv
      - inserter.sv
      - target: test
        files:
          - inserter_assert.sv
          - inserter_tb.sv

/* coarse_flag_blocker.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"
`default_nettype none

module coarse_flag_blocker import inserter_pkg::*; (
    input  flag_t       flags [`NUM_CHANNELS-1:0],
    output chunk_mask_t coarse_flags,
    output logic        unpacked_bit_flags [`NUM_CHANNELS-1:0]
);

    // Packed copy of the sign bits, one per channel.
    logic [`NUM_CHANNELS-1:0] sign_bits;

    // ==================================================
    // Channel flag bits.
    // ==================================================

    genvar gi;
    generate
        for (gi = 0; gi < `NUM_CHANNELS; gi += 1) begin : g_chan
            // A negative flag marks the channel.
            assign sign_bits[gi] = flags[gi][`FLAG_WIDTH-1];
            assign unpacked_bit_flags[gi] = sign_bits[gi];
        end
    endgenerate

    // ==================================================
    // Chunk reduction.
    // ==================================================

    genvar gc;
    generate
        for (gc = 0; gc < `NUM_CHUNKS; gc += 1) begin : g_chunk
            // OR across the eight channels of this chunk.
            assign coarse_flags[gc] = |sign_bits[gc*`CHUNK_SIZE +: `CHUNK_SIZE];
        end
    endgenerate

endmodule
`default_nettype wire

/* fifo_controller.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"
`default_nettype none

module fifo_controller import inserter_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       en_fifo,
    frame_edges_if.sink edges,
    output fifo_mask_t push_n,
    output fifo_mask_t clr,
    output fifo_mask_t init_n,
    output chunk_loc_t start_loc [`NUM_FIFOS-1:0]
);

    // Next FIFO to hand a frame start to.
    logic [$clog2(`NUM_FIFOS)-1:0] ptr;

    // FIFOs that hold a frame in progress.
    fifo_mask_t active;

    // Start chunk of the last frame given to each FIFO.
    chunk_loc_t stored_loc [`NUM_FIFOS-1:0];

    // FIFOs started in this cycle and their start chunks.
    fifo_mask_t start_mask;
    chunk_loc_t new_loc [`NUM_FIFOS-1:0];

    // ==================================================
    // Allocation.
    // ==================================================

    always_comb begin
        logic [$clog2(`NUM_FIFOS)-1:0] idx;

        start_mask = '0;
        idx        = ptr;
        for (int f = 0; f < `NUM_FIFOS; f++) begin
            new_loc[f] = stored_loc[f];
        end

        if (en_fifo && edges.is_there_edge) begin
            for (int k = 0; k < 2; k++) begin
                if (k < int'(edges.num_of_writes)) begin
                    // Pointer arithmetic wraps with the FIFO count.
                    idx = ptr + ($clog2(`NUM_FIFOS))'(k);
                    start_mask[idx] = 1'b1;
                    new_loc[idx]    = (k == 0) ? edges.loc_1 : edges.loc_2;
                end
            end
        end
    end

    // ==================================================
    // Strobes.
    // ==================================================

    // Started FIFOs begin writing in the same cycle.
    assign push_n = en_fifo ? ~(active | start_mask) : '1;
    assign init_n = ~start_mask;

    // Reclaiming a busy FIFO drops its old frame.
    assign clr = start_mask & active;

    genvar gf;
    generate
        for (gf = 0; gf < `NUM_FIFOS; gf += 1) begin : g_loc
            assign start_loc[gf] = new_loc[gf];
        end
    endgenerate

    // ==================================================
    // State.
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr    <= '0;
            active <= '0;
            for (int f = 0; f < `NUM_FIFOS; f++) begin
                stored_loc[f] <= '0;
            end
        end else if (en_fifo) begin
            active <= active | start_mask;
            ptr    <= ptr + edges.num_of_writes;
            for (int f = 0; f < `NUM_FIFOS; f++) begin
                if (start_mask[f]) begin
                    stored_loc[f] <= new_loc[f];
                end
            end
        end
    end

endmodule
`default_nettype wire

/* frame_edges_if.sv */
`timescale 1ns/10ps

interface frame_edges_if import inserter_pkg::*; ();

    // Any frame start in this cycle.
    logic is_there_edge;

    // Lowest and second-lowest edge chunk, 0 when unused.
    chunk_loc_t loc_1;
    chunk_loc_t loc_2;

    // Edge count, capped at two.
    write_count_t num_of_writes;

    modport driver (
        output is_there_edge,
        output loc_1,
        output loc_2,
        output num_of_writes
    );

    modport sink (
        input is_there_edge,
        input loc_1,
        input loc_2,
        input num_of_writes
    );

endinterface

/* inserter.f */
+incdir+.
inserter_pkg.sv
frame_edges_if.sv
coarse_flag_blocker.sv
start_frame_decoder.sv
fifo_controller.sv
inserter.sv
inserter_assert.sv
inserter_tb.sv

/* inserter.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"
`default_nettype none

module inserter import inserter_pkg::*; (
    input  logic clk,
    input  logic reset,

    input  logic en_fifo,

    input  rse_t  rse_vals [`NUM_CHANNELS-1:0],
    input  flag_t flags    [`NUM_CHANNELS-1:0],
    input  sym_t  symbols  [`NUM_CHANNELS-1:0],

    output sym_t       symbols_main [`NUM_CHANNELS-1:0],
    output fifo_mask_t tag,
    output logic       push_n_main,

    // Lanes written to every FIFO.
    output logic        flags_v [`NUM_CHANNELS-1:0],
    output chunk_mask_t cflags_v,
    output rse_t        rse_v   [`NUM_CHANNELS-1:0],

    // Per-FIFO control.
    output chunk_loc_t start_loc [`NUM_FIFOS-1:0],
    output fifo_mask_t push_n_v,
    output fifo_mask_t clr_v,
    output fifo_mask_t init_n_v
);

    chunk_mask_t coarse_flags;

    frame_edges_if edges_if ();

    // ==================================================
    // Pass-through lanes.
    // ==================================================

    genvar gi;
    generate
        for (gi = 0; gi < `NUM_CHANNELS; gi += 1) begin : g_lane
            assign symbols_main[gi] = symbols[gi];
            assign rse_v[gi]        = rse_vals[gi];
        end
    endgenerate

    assign cflags_v    = coarse_flags;
    assign tag         = ~push_n_v;
    assign push_n_main = ~en_fifo;

    // ==================================================
    // Frame start path.
    // ==================================================

    coarse_flag_blocker cfb_i (
        .flags              (flags),
        .coarse_flags       (coarse_flags),
        .unpacked_bit_flags (flags_v)
    );

    start_frame_decoder sfd_i (
        .clk          (clk),
        .reset        (reset),
        .en_fifo      (en_fifo),
        .coarse_flags (coarse_flags),
        .edges        (edges_if.driver)
    );

    fifo_controller fc_i (
        .clk       (clk),
        .reset     (reset),
        .en_fifo   (en_fifo),
        .edges     (edges_if.sink),
        .push_n    (push_n_v),
        .clr       (clr_v),
        .init_n    (init_n_v),
        .start_loc (start_loc)
    );

endmodule
`default_nettype wire

/* inserter_assert.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"

module inserter_assert import inserter_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       en_fifo,
    input fifo_mask_t push_n,
    input fifo_mask_t clr,
    input fifo_mask_t init_n
);

    // ==================================================
    // FIFO strobe rules.
    // ==================================================

    // A FIFO being started also writes in the same cycle.
    init_implies_push: assert property (
        @(posedge clk) disable iff (reset)
        (~init_n & push_n) == '0
    ) else $error("init_n low without push_n low, init_n=%b push_n=%b", init_n, push_n);

    // Clear only goes with a restart.
    clr_implies_init: assert property (
        @(posedge clk) disable iff (reset)
        (clr & init_n) == '0
    ) else $error("clr high without init_n low, clr=%b init_n=%b", clr, init_n);

    // Idle cycles carry no strobe at all.
    idle_no_strobe: assert property (
        @(posedge clk) disable iff (reset)
        !en_fifo |-> (push_n == '1 && init_n == '1 && clr == '0)
    ) else $error("strobe active with en_fifo low, push_n=%b init_n=%b clr=%b",
                  push_n, init_n, clr);

    // At most two frame starts per cycle.
    init_at_most_two: assert property (
        @(posedge clk) disable iff (reset)
        $countones(~init_n) <= 2
    ) else $error("more than two FIFOs started at once, init_n=%b", init_n);

endmodule

bind fifo_controller inserter_assert fc_checks (
    .clk     (clk),
    .reset   (reset),
    .en_fifo (en_fifo),
    .push_n  (push_n),
    .clr     (clr),
    .init_n  (init_n)
);

/* inserter_config.svh */
`ifndef INSERTER_CONFIG_SVH
`define INSERTER_CONFIG_SVH

// ==================================================
// Lane geometry.
// ==================================================

// Channels delivered per cycle.
`define NUM_CHANNELS 40

// Coarse flag groups, each CHUNK_SIZE channels wide.
`define NUM_CHUNKS 5
`define CHUNK_SIZE 8

// Viterbi FIFOs served in round-robin order.
`define NUM_FIFOS 4

// ==================================================
// Field widths.
// ==================================================

// Signed reliability value per channel.
`define RSE_WIDTH 8

// Signed flag, negative marks a frame boundary channel.
`define FLAG_WIDTH 8

// Signed soft symbol.
`define SYM_WIDTH 3

`endif

/* inserter_pkg.sv */
`include "inserter_config.svh"

package inserter_pkg;

    // ==================================================
    // Per-channel payload types.
    // ==================================================

    // Reliability value.
    typedef logic signed [`RSE_WIDTH-1:0] rse_t;

    // Flag value, only the sign is looked at.
    typedef logic signed [`FLAG_WIDTH-1:0] flag_t;

    // Soft symbol.
    typedef logic signed [`SYM_WIDTH-1:0] sym_t;

    // ==================================================
    // Control types.
    // ==================================================

    // One bit per chunk.
    typedef logic [`NUM_CHUNKS-1:0] chunk_mask_t;

    // Chunk index within one cycle.
    typedef logic [$clog2(`NUM_CHUNKS)-1:0] chunk_loc_t;

    // Frame starts found in one cycle, 0 to 2.
    typedef logic [1:0] write_count_t;

    // One bit per Viterbi FIFO.
    typedef logic [`NUM_FIFOS-1:0] fifo_mask_t;

endpackage

/* inserter_tb.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"

module inserter_tb import inserter_pkg::*; ();

    localparam int RANDOM_CYCLES   = 2000;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int MARGIN_CYCLES   = 200;
    localparam int TIMEOUT_CYCLES  = RANDOM_CYCLES + DIRECTED_CYCLES
                                     + 3 * RESET_CYCLES + MARGIN_CYCLES;

    // Starts high so the first clock edge is a falling one.
    logic clk = 1'b1;
    logic reset;
    logic en_fifo;

    rse_t  rse_vals [`NUM_CHANNELS-1:0];
    flag_t flags    [`NUM_CHANNELS-1:0];
    sym_t  symbols  [`NUM_CHANNELS-1:0];

    sym_t        symbols_main [`NUM_CHANNELS-1:0];
    fifo_mask_t  tag;
    logic        push_n_main;
    logic        flags_v [`NUM_CHANNELS-1:0];
    chunk_mask_t cflags_v;
    rse_t        rse_v   [`NUM_CHANNELS-1:0];
    chunk_loc_t  start_loc [`NUM_FIFOS-1:0];
    fifo_mask_t  push_n_v;
    fifo_mask_t  clr_v;
    fifo_mask_t  init_n_v;

    // Reference model state.
    logic       m_last;
    int         m_ptr;
    fifo_mask_t m_active;
    chunk_loc_t m_loc [`NUM_FIFOS-1:0];

    logic [31:0] lfsr;
    string       test_name;

    inserter uut (
        .clk          (clk),
        .reset        (reset),
        .en_fifo      (en_fifo),
        .rse_vals     (rse_vals),
        .flags        (flags),
        .symbols      (symbols),
        .symbols_main (symbols_main),
        .tag          (tag),
        .push_n_main  (push_n_main),
        .flags_v      (flags_v),
        .cflags_v     (cflags_v),
        .rse_v        (rse_v),
        .start_loc    (start_loc),
        .push_n_v     (push_n_v),
        .clr_v        (clr_v),
        .init_n_v     (init_n_v)
    );

    always #10 clk = ~clk;

    // ==================================================
    // Failure reporting and compare tasks.
    // ==================================================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_sym(input string name, input sym_t exp, input sym_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_rse(input string name, input rse_t exp, input rse_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_chunk_mask(input string name, input chunk_mask_t exp,
                                    input chunk_mask_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_fifo_mask(input string name, input fifo_mask_t exp,
                                   input fifo_mask_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_loc(input string name, input chunk_loc_t exp, input chunk_loc_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ==================================================
    // Random source.
    // ==================================================

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // ==================================================
    // Stimulus.
    // ==================================================

    task automatic drive_lanes();
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            rse_vals[i] = rse_t'(take_bits(`RSE_WIDTH));
            symbols[i]  = sym_t'(take_bits(`SYM_WIDTH));
        end
    endtask

    // Half of the chunks stay quiet and the rest carry raw random flags.
    task automatic drive_random();
        logic [31:0] bits;
        reset   = 1'b0;
        en_fifo = (take_bits(2) != 0);
        for (int c = 0; c < `NUM_CHUNKS; c++) begin
            if (take_bits(1) == 0) begin
                for (int j = 0; j < `CHUNK_SIZE; j++) begin
                    bits = take_bits(`FLAG_WIDTH - 1);
                    flags[c*`CHUNK_SIZE + j] = flag_t'({1'b0, bits[`FLAG_WIDTH-2:0]});
                end
            end else begin
                for (int j = 0; j < `CHUNK_SIZE; j++) begin
                    bits = take_bits(`FLAG_WIDTH);
                    flags[c*`CHUNK_SIZE + j] = flag_t'(bits[`FLAG_WIDTH-1:0]);
                end
            end
        end
        drive_lanes();
    endtask

    // One negative channel in each chunk that is set in the mask.
    task automatic drive_pattern(input chunk_mask_t mask, input logic en);
        logic [31:0] bits;
        int          neg;
        reset   = 1'b0;
        en_fifo = en;
        for (int c = 0; c < `NUM_CHUNKS; c++) begin
            neg = c * `CHUNK_SIZE + int'(take_bits(3));
            for (int j = 0; j < `CHUNK_SIZE; j++) begin
                bits = take_bits(`FLAG_WIDTH - 1);
                flags[c*`CHUNK_SIZE + j] =
                    flag_t'({mask[c] && (c*`CHUNK_SIZE + j == neg), bits[`FLAG_WIDTH-2:0]});
            end
        end
        drive_lanes();
    endtask

    task automatic model_reset();
        m_last   = 1'b1;
        m_ptr    = 0;
        m_active = '0;
        for (int f = 0; f < `NUM_FIFOS; f++) begin
            m_loc[f] = '0;
        end
    endtask

    task automatic apply_reset();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            drive_random();
            reset = 1'b1;
        end
        model_reset();
    endtask

    // ==================================================
    // Reference model and checks.
    // ==================================================

    task automatic settle_and_check();
        chunk_mask_t exp_cflags;
        logic        prev;
        int          n_edges;
        int          slot;
        chunk_loc_t  locs [0:1];
        fifo_mask_t  started;
        fifo_mask_t  exp_clr;
        fifo_mask_t  exp_push_n;
        chunk_loc_t  exp_loc [`NUM_FIFOS-1:0];
        #2;
        exp_cflags = '0;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            check_sym($sformatf("%s symbols_main[%0d]", test_name, i), symbols[i],
                      symbols_main[i]);
            check_rse($sformatf("%s rse_v[%0d]", test_name, i), rse_vals[i], rse_v[i]);
            check_bit($sformatf("%s flags_v[%0d]", test_name, i), flags[i] < 0, flags_v[i]);
            if (flags[i] < 0) begin
                exp_cflags[i / `CHUNK_SIZE] = 1'b1;
            end
        end
        check_chunk_mask({test_name, " cflags_v"}, exp_cflags, cflags_v);
        check_bit({test_name, " push_n_main"}, !en_fifo, push_n_main);

        // Only the first two rising edges of the chunk stream are kept.
        prev    = m_last;
        n_edges = 0;
        locs[0] = '0;
        locs[1] = '0;
        for (int c = 0; c < `NUM_CHUNKS; c++) begin
            if (exp_cflags[c] && !prev) begin
                if (n_edges < 2) begin
                    locs[n_edges] = chunk_loc_t'(c);
                end
                n_edges++;
            end
            prev = exp_cflags[c];
        end
        if (n_edges > 2) begin
            n_edges = 2;
        end

        started = '0;
        exp_clr = '0;
        for (int f = 0; f < `NUM_FIFOS; f++) begin
            exp_loc[f] = m_loc[f];
        end
        if (en_fifo) begin
            for (int k = 0; k < n_edges; k++) begin
                slot          = (m_ptr + k) % `NUM_FIFOS;
                started[slot] = 1'b1;
                exp_loc[slot] = locs[k];
                exp_clr[slot] = m_active[slot];
            end
        end
        exp_push_n = en_fifo ? ~(m_active | started) : '1;

        check_fifo_mask({test_name, " push_n_v"}, exp_push_n, push_n_v);
        check_fifo_mask({test_name, " tag"}, ~exp_push_n, tag);
        check_fifo_mask({test_name, " init_n_v"}, ~started, init_n_v);
        check_fifo_mask({test_name, " clr_v"}, exp_clr, clr_v);
        for (int f = 0; f < `NUM_FIFOS; f++) begin
            check_loc($sformatf("%s start_loc[%0d]", test_name, f), exp_loc[f], start_loc[f]);
        end

        if (en_fifo) begin
            m_active = m_active | started;
            m_ptr    = (m_ptr + n_edges) % `NUM_FIFOS;
            for (int f = 0; f < `NUM_FIFOS; f++) begin
                m_loc[f] = exp_loc[f];
            end
            m_last = exp_cflags[`NUM_CHUNKS-1];
        end
    endtask

    task automatic pattern_cycle(input chunk_mask_t mask, input logic en);
        @(negedge clk);
        drive_pattern(mask, en);
        settle_and_check();
    endtask

    // ==================================================
    // Test sequence.
    // ==================================================

    initial begin
        reset   = 1'b1;
        en_fifo = 1'b0;
        lfsr    = 32'h9c55;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            rse_vals[i] = '0;
            flags[i]    = '0;
            symbols[i]  = '0;
        end
        model_reset();
        apply_reset();

        test_name = "edges";
        pattern_cycle(5'b11111, 1'b1);
        pattern_cycle(5'b00000, 1'b1);
        pattern_cycle(5'b00001, 1'b1);

        test_name = "coarse_flags";
        for (int c = 0; c < `NUM_CHUNKS; c++) begin
            pattern_cycle(chunk_mask_t'(1 << c), 1'b1);
        end

        test_name = "three_edges";
        pattern_cycle(5'b00000, 1'b1);
        pattern_cycle(5'b10101, 1'b1);

        // Two starts per cycle wrap the pointer and reclaim busy FIFOs.
        test_name = "allocation";
        for (int n = 0; n < 6; n++) begin
            pattern_cycle(5'b01010, 1'b1);
            pattern_cycle(5'b10101, 1'b1);
        end

        test_name = "en_low";
        for (int n = 0; n < 4; n++) begin
            pattern_cycle(5'b01010, 1'b0);
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            test_name = "random";
            if (n == RANDOM_CYCLES / 2) begin
                apply_reset();
                test_name = "mid_reset";
            end
            @(negedge clk);
            drive_random();
            settle_and_check();
        end

        $display("All checks passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        fail_run("Watchdog expired before the tests finished, the run timed out");
    end

endmodule

/* start_frame_decoder.sv */
`timescale 1ns/10ps
`include "inserter_config.svh"
`default_nettype none

module start_frame_decoder import inserter_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        en_fifo,
    input  chunk_mask_t coarse_flags,
    frame_edges_if.driver edges
);

    // Last chunk of the previous enabled cycle.
    logic last_bit;

    // Predecessor of each chunk in the stream.
    chunk_mask_t prev_flags;

    // Rising edges of this cycle.
    chunk_mask_t edge_vec;

    write_count_t count;
    chunk_loc_t   first_loc;
    chunk_loc_t   second_loc;

    // ==================================================
    // Edge detection.
    // ==================================================

    assign prev_flags = {coarse_flags[`NUM_CHUNKS-2:0], last_bit};
    assign edge_vec   = coarse_flags & ~prev_flags;

    // Priority search from chunk 0, edges past the second are dropped.
    always_comb begin
        count      = '0;
        first_loc  = '0;
        second_loc = '0;
        for (int c = 0; c < `NUM_CHUNKS; c++) begin
            if (edge_vec[c]) begin
                if (count == 2'd0) begin
                    first_loc = chunk_loc_t'(c);
                    count     = 2'd1;
                end else if (count == 2'd1) begin
                    second_loc = chunk_loc_t'(c);
                    count      = 2'd2;
                end
            end
        end
    end

    assign edges.is_there_edge = (count != 2'd0);
    assign edges.loc_1         = first_loc;
    assign edges.loc_2         = second_loc;
    assign edges.num_of_writes = count;

    // ==================================================
    // Stream history.
    // ==================================================

    // Resets high so a stream that starts high gives no edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            last_bit <= 1'b1;
        end else if (en_fifo) begin
            last_bit <= coarse_flags[`NUM_CHUNKS-1];
        end
    end

endmodule
`default_nettype wire
